//--- hdl/ramio_macros.svh
// ramio address map and build constants
// shared by the bridge, the UART blocks and the top level
`ifndef RAMIO_MACROS_SVH
`define RAMIO_MACROS_SVH

// I/O registers at the top of the address map
// write the low nibble to drive the LEDs
`define RAMIO_ADDR_LED 32'hffff_fffc

// UART transmit register, reads all ones when idle
`define RAMIO_ADDR_UART_OUT 32'hffff_fff8

// UART receive register, cleared to all ones by a read
`define RAMIO_ADDR_UART_IN 32'hffff_fff4

// clocks per UART bit, kept small for simulation
// must be even so the start bit check lands mid-bit
`define RAMIO_CLKS_PER_BIT 8

// default word memory depth in 32-bit words
`define RAMIO_RAM_WORDS 256

`endif

//--- hdl/ramio_pkg.sv
// ramio shared types
// access sizes on the core bus and the UART state encodings
package ramio_pkg;

  // access size on the core bus
  // write_type uses all of it, read_type uses it in its low two bits
  typedef enum logic [1:0] {
    size_none = 2'b00,
    size_byte = 2'b01,
    size_half = 2'b10,
    size_word = 2'b11
  } access_size_e;

  // serializer states, tx_done waits for go to drop
  typedef enum logic [2:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop,
    tx_done
  } tx_state_e;

  // deserializer states, rx_hold keeps data_ready up until go drops
  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop,
    rx_hold
  } rx_state_e;

endpackage

//--- hdl/mem_port_if.sv
// word memory port
// request and response between the bridge and the word RAM
`timescale 1ns/1ps

interface mem_port_if;

  // request, driven by the bridge
  logic        enable;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [3:0]  write_enable;

  // response, driven by the memory
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;

  // bridge side
  modport client (
    output enable, address, data_in, write_enable,
    input  data_out, data_out_ready, busy
  );

  // memory side
  modport memory (
    input  enable, address, data_in, write_enable,
    output data_out, data_out_ready, busy
  );

endinterface

//--- hdl/word_ram.sv
// word_ram: byte-enabled 32-bit word memory
// one-cycle registered read, ready follows the registered address
`timescale 1ns/1ps

module word_ram #(
  parameter int unsigned WORDS = 256
) (
  input logic         clk,
  input logic         rst_n,
  mem_port_if.memory  mem
);

  // word index width, address bits [1:0] are the byte lane
  localparam int unsigned AW = $clog2(WORDS);

  logic [31:0]   ram [WORDS];
  logic [AW-1:0] idx;

  // address captured at the last edge with enable high
  logic [31:0]   addr_q;
  // set when the previous cycle had enable high
  logic          valid_q;
  logic [31:0]   rd_q;

  assign idx = mem.address[AW+1:2];

  // storage and registered read port
  always_ff @(posedge clk) begin
    if (mem.enable) begin
      // read returns the word as it was before this edge's write
      rd_q <= ram[idx];
      for (int b = 0; b < 4; b++) begin
        if (mem.write_enable[b]) begin
          ram[idx][8*b +: 8] <= mem.data_in[8*b +: 8];
        end
      end
    end
  end

  // handshake tracking
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      addr_q  <= '0;
    end else begin
      valid_q <= mem.enable;
      if (mem.enable) begin
        addr_q <= mem.address;
      end
    end
  end

  // ready only while the request still targets the captured word
  assign mem.data_out_ready = mem.enable && valid_q && (mem.address == addr_q);
  assign mem.busy           = mem.enable && !mem.data_out_ready;
  assign mem.data_out       = rd_q;

endmodule

//--- hdl/uart_tx.sv
// uart_tx: 8N1 serializer
// go starts a frame, bsy stays high until the stop bit ends
// then the FSM waits for go to drop
`timescale 1ns/1ps
`include "ramio_macros.svh"

module uart_tx import ramio_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  output logic       tx,
  input  logic [7:0] data,
  input  logic       go,
  output logic       bsy
);

  localparam int unsigned CNT_W = $clog2(`RAMIO_CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`RAMIO_CLKS_PER_BIT - 1);

  tx_state_e        state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  // byte latched at frame start, later writes do not disturb it
  logic [7:0]       shreg;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= tx_idle;
      tx      <= 1'b1;
      bsy     <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
    end else begin
      unique case (state)
        tx_idle: begin
          tx <= 1'b1;
          if (go) begin
            // start bit goes out on this edge
            shreg <= data;
            bsy   <= 1'b1;
            cnt   <= '0;
            tx    <= 1'b0;
            state <= tx_start;
          end
        end
        tx_start: begin
          if (cnt == BIT_LAST) begin
            cnt     <= '0;
            bit_idx <= '0;
            tx      <= shreg[0];
            state   <= tx_data;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        tx_data: begin
          if (cnt == BIT_LAST) begin
            cnt <= '0;
            if (bit_idx == 3'd7) begin
              // stop bit
              tx    <= 1'b1;
              state <= tx_stop;
            end else begin
              // lsb first, next bit sits in shreg[1]
              bit_idx <= bit_idx + 1'b1;
              shreg   <= shreg >> 1;
              tx      <= shreg[1];
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        tx_stop: begin
          if (cnt == BIT_LAST) begin
            cnt   <= '0;
            bsy   <= 1'b0;
            state <= tx_done;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        tx_done: begin
          // second half of the handshake
          if (!go) begin
            state <= tx_idle;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

endmodule

//--- hdl/uart_rx.sv
// uart_rx: 8N1 deserializer
// start bit checked at half a bit, data sampled mid-bit
// a good frame is held with data_ready until go drops
`timescale 1ns/1ps
`include "ramio_macros.svh"

module uart_rx import ramio_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       go,
  output logic [7:0] data,
  output logic       data_ready
);

  localparam int unsigned CNT_W = $clog2(`RAMIO_CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`RAMIO_CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`RAMIO_CLKS_PER_BIT / 2 - 1);

  rx_state_e        state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;

  // two-flop synchronizer plus one delay for edge detection
  logic rx_meta;
  logic rx_sync;
  logic rx_prev;
  logic fall;

  assign fall = rx_prev && !rx_sync;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= rx_idle;
      cnt        <= '0;
      bit_idx    <= '0;
      data_ready <= 1'b0;
    end else begin
      unique case (state)
        rx_idle: begin
          // only listen while the bridge has go up
          if (go && fall) begin
            cnt   <= '0;
            state <= rx_start;
          end
        end
        rx_start: begin
          if (cnt == HALF_LAST) begin
            cnt <= '0;
            if (!rx_sync) begin
              bit_idx <= '0;
              state   <= rx_data;
            end else begin
              // glitch, not a start bit
              state <= rx_idle;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        rx_data: begin
          if (cnt == BIT_LAST) begin
            cnt  <= '0;
            // lsb arrives first, shift in from the top
            data <= {rx_sync, data[7:1]};
            if (bit_idx == 3'd7) begin
              state <= rx_stop;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        rx_stop: begin
          if (cnt == BIT_LAST) begin
            cnt <= '0;
            if (rx_sync) begin
              data_ready <= 1'b1;
              state      <= rx_hold;
            end else begin
              // framing error, drop the byte
              state <= rx_idle;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        rx_hold: begin
          // bridge took the byte and dropped go
          if (!go) begin
            data_ready <= 1'b0;
            state      <= rx_idle;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

endmodule

//--- hdl/ramio.sv
// ramio: core bus bridge to word RAM and memory-mapped I/O
// decodes the LED and UART registers, packs byte-lane writes
// and extends read lanes, runs both UART handshakes
`timescale 1ns/1ps
`include "ramio_macros.svh"

module ramio import ramio_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable,
  input  logic [2:0]  read_type,
  input  logic [1:0]  write_type,
  input  logic [31:0] address,
  input  logic [31:0] data_in,
  output logic [31:0] data_out,
  output logic        data_out_ready,
  output logic        busy,
  output logic [3:0]  led,
  mem_port_if.client  mem,
  output logic [7:0]  tx_data,
  output logic        tx_go,
  input  logic        tx_bsy,
  input  logic [7:0]  rx_data,
  input  logic        rx_ready,
  output logic        rx_go
);

  access_size_e wr_size;
  access_size_e rd_size;

  logic is_led;
  logic is_uart_out;
  logic is_uart_in;
  logic is_io;

  // high only on the first cycle of an access
  logic enable_q;
  logic first;

  logic [31:0] tx_sending;
  logic [31:0] rx_received;
  // go was raised last cycle, bsy is not valid yet
  logic        tx_first;

  logic [31:0] byte_shift;
  logic [31:0] half_shift;
  logic [7:0]  byte_lane;
  logic [15:0] half_lane;

  assign wr_size = access_size_e'(write_type);
  assign rd_size = access_size_e'(read_type[1:0]);

  // address decode
  assign is_led      = (address == `RAMIO_ADDR_LED);
  assign is_uart_out = (address == `RAMIO_ADDR_UART_OUT);
  assign is_uart_in  = (address == `RAMIO_ADDR_UART_IN);
  assign is_io       = is_led || is_uart_out || is_uart_in;

  assign first = enable && !enable_q;

  // I/O completes in the same cycle, RAM answers through the port
  assign data_out_ready = (enable && is_io) ? 1'b1 : mem.data_out_ready;
  assign busy           = (enable && is_io) ? 1'b0 : mem.busy;

  // RAM request, word aligned
  assign mem.enable  = enable && !is_io;
  assign mem.address = {address[31:2], 2'b00};

  // write packer, lanes are replicated and the mask picks the bytes
  // misaligned halves and words get an empty mask
  always_comb begin
    mem.write_enable = 4'b0000;
    mem.data_in      = '0;
    unique case (wr_size)
      size_byte: begin
        mem.write_enable = 4'b0001 << address[1:0];
        mem.data_in      = {4{data_in[7:0]}};
      end
      size_half: begin
        if (!address[0]) begin
          mem.write_enable = 4'b0011 << address[1:0];
          mem.data_in      = {2{data_in[15:0]}};
        end
      end
      size_word: begin
        if (address[1:0] == 2'b00) begin
          mem.write_enable = 4'b1111;
          mem.data_in      = data_in;
        end
      end
      default: ;
    endcase
  end

  // read lane select
  assign byte_shift = mem.data_out >> {address[1:0], 3'b000};
  assign half_shift = mem.data_out >> {address[1], 4'b0000};
  assign byte_lane  = byte_shift[7:0];
  assign half_lane  = half_shift[15:0];

  // read mux, bit 2 of read_type asks for sign extension
  always_comb begin
    data_out = '0;
    if (enable) begin
      if (is_uart_out) begin
        data_out = tx_sending;
      end else if (is_uart_in) begin
        data_out = rx_received;
      end else if (is_led) begin
        data_out = {28'h0, led};
      end else begin
        unique case (rd_size)
          size_byte: begin
            data_out = {{24{read_type[2] & byte_lane[7]}}, byte_lane};
          end
          size_half: begin
            // odd half-word address reads zero
            if (!address[0]) begin
              data_out = {{16{read_type[2] & half_lane[15]}}, half_lane};
            end
          end
          size_word: begin
            if (address[1:0] == 2'b00) begin
              data_out = mem.data_out;
            end
          end
          default: ;
        endcase
      end
    end
  end

  assign tx_data = tx_sending[7:0];

  // I/O registers and UART handshakes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enable_q    <= 1'b0;
      led         <= 4'b1111;
      tx_sending  <= '1;
      tx_go       <= 1'b0;
      tx_first    <= 1'b0;
      rx_received <= '1;
      rx_go       <= 1'b1;
    end else begin
      enable_q <= enable;
      tx_first <= 1'b0;

      // receive side, a read clears the register
      // a byte arriving at the same edge waits one cycle in uart_rx
      if (first && is_uart_in && rd_size != size_none) begin
        rx_received <= '1;
      end else if (rx_go && rx_ready) begin
        rx_received <= {24'h0, rx_data};
        rx_go       <= 1'b0;
      end

      // go stays low for a single cycle after taking a byte
      if (!rx_go) begin
        rx_go <= 1'b1;
      end

      // frame finished, acknowledge and mark idle
      if (tx_go && !tx_bsy && !tx_first) begin
        tx_go      <= 1'b0;
        tx_sending <= '1;
      end

      // a new write wins over the acknowledge above
      if (first && is_uart_out && wr_size != size_none) begin
        tx_sending <= {24'h0, data_in[7:0]};
        tx_go      <= 1'b1;
        tx_first   <= 1'b1;
      end

      if (first && is_led && wr_size != size_none) begin
        led <= data_in[3:0];
      end
    end
  end

endmodule

//--- hdl/soc_io_top.sv
// soc_io_top: RAM and I/O subsystem for the core bus
// bridge, word memory and the UART pair
`timescale 1ns/1ps
`include "ramio_macros.svh"

module soc_io_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable,
  input  logic [2:0]  read_type,
  input  logic [1:0]  write_type,
  input  logic [31:0] address,
  input  logic [31:0] data_in,
  output logic [31:0] data_out,
  output logic        data_out_ready,
  output logic        busy,
  output logic [3:0]  led,
  output logic        uart_tx,
  input  logic        uart_rx
);

  // bridge to UART links
  logic [7:0] tx_data;
  logic       tx_go;
  logic       tx_bsy;
  logic [7:0] rx_data;
  logic       rx_ready;
  logic       rx_go;

  mem_port_if mem_bus ();

  ramio u_ramio (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable),
    .read_type      (read_type),
    .write_type     (write_type),
    .address        (address),
    .data_in        (data_in),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .busy           (busy),
    .led            (led),
    .mem            (mem_bus.client),
    .tx_data        (tx_data),
    .tx_go          (tx_go),
    .tx_bsy         (tx_bsy),
    .rx_data        (rx_data),
    .rx_ready       (rx_ready),
    .rx_go          (rx_go)
  );

  word_ram #(
    .WORDS (`RAMIO_RAM_WORDS)
  ) u_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .mem   (mem_bus.memory)
  );

  uart_tx u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .tx    (uart_tx),
    .data  (tx_data),
    .go    (tx_go),
    .bsy   (tx_bsy)
  );

  uart_rx u_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (uart_rx),
    .go         (rx_go),
    .data       (rx_data),
    .data_ready (rx_ready)
  );

endmodule

//--- bench/tb_soc_io.sv
// testbench for soc_io_top
// drives the core bus against a shadow memory, loops the UART back
`timescale 1ns/1ps
`include "ramio_macros.svh"

module tb_soc_io import ramio_pkg::*; ();

  localparam int BIT_CYCLES = `RAMIO_CLKS_PER_BIT;
  localparam int IDX_BITS   = $clog2(`RAMIO_RAM_WORDS);
  localparam int NUM_SLOTS  = 8;
  // an I/O poll takes two cycles so this spans 20 bit periods
  localparam int MAX_POLLS  = (20 * BIT_CYCLES) / 2;
  // one 8N1 frame in ns at the 20 ns clock period
  localparam time FRAME_NS  = time'(10 * BIT_CYCLES * 20);

  logic        clk;
  logic        rst_n;
  logic        enable;
  logic [2:0]  read_type;
  logic [1:0]  write_type;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;
  logic [3:0]  led;
  logic        tx_line;
  logic        rx_line;
  logic        io_access;

  logic [31:0]         shadow [`RAMIO_RAM_WORDS];
  logic [IDX_BITS-1:0] slots [NUM_SLOTS];
  logic [31:0]         lfsr_state;

  soc_io_top uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable),
    .read_type      (read_type),
    .write_type     (write_type),
    .address        (address),
    .data_in        (data_in),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .busy           (busy),
    .led            (led),
    .uart_tx        (tx_line),
    .uart_rx        (rx_line)
  );

  // loopback, line held idle during reset
  assign rx_line = rst_n ? tx_line : 1'b1;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic io_addr(input logic [31:0] a);
    return (a == `RAMIO_ADDR_LED) || (a == `RAMIO_ADDR_UART_OUT) ||
           (a == `RAMIO_ADDR_UART_IN);
  endfunction

  assign io_access = enable && io_addr(address);

  task automatic flag_mismatch(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, got);
    $display("Test failed");
    $fatal(1, "value mismatch on %s", name);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timed out at %0t waiting for %s", $time, what);
    $display("Test failed");
    $fatal(1, "timeout");
  endtask

  // I/O answers in the cycle it is driven
  io_ready_check: assert property (@(posedge clk) disable iff (!rst_n)
    io_access |-> data_out_ready)
    else flag_mismatch("data_out_ready", 32'h1, {31'h0, $sampled(data_out_ready)});

  io_busy_check: assert property (@(posedge clk) disable iff (!rst_n)
    io_access |-> !busy)
    else flag_mismatch("busy", 32'h0, {31'h0, $sampled(busy)});

  // nothing answers without a request
  idle_ready_check: assert property (@(posedge clk) disable iff (!rst_n)
    !enable |-> !data_out_ready)
    else flag_mismatch("data_out_ready", 32'h0, {31'h0, $sampled(data_out_ready)});

  idle_busy_check: assert property (@(posedge clk) disable iff (!rst_n)
    !enable |-> !busy)
    else flag_mismatch("busy", 32'h0, {31'h0, $sampled(busy)});

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit, bits fill from the bottom
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // expected read value, lane picked by the byte offset
  function automatic logic [31:0] extend_lane(input logic [31:0] word,
                                              input logic [1:0] offset,
                                              input logic [2:0] rtype);
    logic [7:0]  b;
    logic [15:0] h;
    b = 8'(word >> (8 * offset));
    h = 16'(word >> (16 * offset[1]));
    case (access_size_e'(rtype[1:0]))
      size_byte: return rtype[2] ? {{24{b[7]}}, b} : {24'h0, b};
      size_half: return rtype[2] ? {{16{h[15]}}, h} : {16'h0, h};
      size_word: return word;
      default:   return 32'h0;
    endcase
  endfunction

  // one bus access, starts and ends 2 ns after a rising edge
  task automatic run_access(input logic [31:0] addr, input logic [2:0] rtype,
                            input logic [1:0] wtype, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int waited;
    waited = 0;
    enable     = 1'b1;
    address    = addr;
    read_type  = rtype;
    write_type = wtype;
    data_in    = wdata;
    @(negedge clk);
    // RAM has not answered yet in the first cycle
    if (!io_addr(addr)) begin
      assert (busy) else flag_mismatch("busy", 32'h1, {31'h0, busy});
      assert (!data_out_ready)
        else flag_mismatch("data_out_ready", 32'h0, {31'h0, data_out_ready});
    end
    while (!data_out_ready) begin
      if (waited == 20) abort_on_timeout("data_out_ready");
      waited++;
      @(negedge clk);
    end
    rdata = data_out;
    @(posedge clk);
    #2;
    enable     = 1'b0;
    read_type  = 3'b000;
    write_type = 2'b00;
    // one idle cycle between accesses
    @(posedge clk);
    #2;
  endtask

  task automatic store(input logic [31:0] addr, input logic [1:0] wtype,
                       input logic [31:0] wdata);
    logic [31:0] ignored;
    run_access(addr, 3'b000, wtype, wdata, ignored);
  endtask

  task automatic load_and_compare(input string name, input logic [31:0] addr,
                                  input logic [2:0] rtype, input logic [31:0] exp);
    logic [31:0] got;
    run_access(addr, rtype, 2'b00, 32'h0, got);
    assert (got === exp) else flag_mismatch(name, exp, got);
  endtask

  // UART_OUT holds the byte until the frame ends
  task automatic tx_drain(input logic [7:0] sent, input time sent_at);
    logic [31:0] got;
    int polls;
    polls = 0;
    got = {24'h0, sent};
    while (got !== 32'hffff_ffff) begin
      if (polls == MAX_POLLS) abort_on_timeout("end of the UART frame");
      polls++;
      run_access(`RAMIO_ADDR_UART_OUT, {1'b0, size_word}, size_none, 32'h0, got);
      assert (got === 32'hffff_ffff || got === {24'h0, sent})
        else flag_mismatch("uart_out", {24'h0, sent}, got);
    end
    // all ones only once a whole frame has gone out
    assert ($time - sent_at >= FRAME_NS)
      else flag_mismatch("uart_out", {24'h0, sent}, got);
  endtask

  // poll UART_IN until the looped byte shows up
  task automatic rx_collect(input logic [7:0] sent);
    logic [31:0] got;
    int polls;
    polls = 0;
    got = 32'hffff_ffff;
    while (got === 32'hffff_ffff) begin
      if (polls == MAX_POLLS) abort_on_timeout("the received byte");
      polls++;
      run_access(`RAMIO_ADDR_UART_IN, {1'b0, size_word}, size_none, 32'h0, got);
    end
    assert (got === {24'h0, sent}) else flag_mismatch("uart_in", {24'h0, sent}, got);
  endtask

  initial begin : stimulus
    logic [31:0] word;
    logic [31:0] tmp;
    logic [31:0] base;
    logic [31:0] mask;
    logic [31:0] placed;
    logic [2:0]  rtype;
    logic [1:0]  lane;
    logic [1:0]  wsize;
    logic [3:0]  nib;
    logic [7:0]  tx_byte;
    time         sent_at;
    lfsr_state = 32'hd045;
    rst_n      = 1'b0;
    enable     = 1'b0;
    read_type  = 3'b000;
    write_type = 2'b00;
    address    = 32'h0;
    data_in    = 32'h0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;

    // reset state of the I/O side
    assert (led === 4'b1111) else flag_mismatch("led", 32'hf, {28'h0, led});
    assert (tx_line === 1'b1) else flag_mismatch("uart_tx", 32'h1, {31'h0, tx_line});
    load_and_compare("uart_out", `RAMIO_ADDR_UART_OUT, {1'b0, size_word}, 32'hffff_ffff);
    load_and_compare("uart_in", `RAMIO_ADDR_UART_IN, {1'b0, size_word}, 32'hffff_ffff);

    // random words to random slots
    for (int i = 0; i < NUM_SLOTS; i++) begin
      tmp      = rand_bits(IDX_BITS);
      slots[i] = tmp[IDX_BITS-1:0];
      word     = rand_bits(32);
      shadow[slots[i]] = word;
      store(32'(slots[i]) << 2, size_word, word);
    end

    // word, byte and half reads, signed and unsigned
    for (int i = 0; i < NUM_SLOTS; i++) begin
      word = shadow[slots[i]];
      base = 32'(slots[i]) << 2;
      load_and_compare("data_out", base, {1'b0, size_word}, word);
      for (int off = 0; off < 4; off++) begin
        for (int s = 0; s < 2; s++) begin
          rtype = {s[0], size_byte};
          load_and_compare("data_out", base + off, rtype, extend_lane(word, off[1:0], rtype));
          if (off % 2 == 0) begin
            rtype = {s[0], size_half};
            load_and_compare("data_out", base + off, rtype,
                             extend_lane(word, off[1:0], rtype));
          end
        end
      end
    end

    // partial writes merge into the stored word
    for (int i = 0; i < 12; i++) begin
      tmp  = rand_bits(3);
      base = 32'(slots[tmp[2:0]]) << 2;
      word = rand_bits(32);
      tmp  = rand_bits(1);
      if (tmp[0]) begin
        wsize  = size_byte;
        tmp    = rand_bits(2);
        lane   = tmp[1:0];
        mask   = 32'h0000_00ff << (8 * lane);
        placed = 32'(word[7:0]) << (8 * lane);
      end else begin
        wsize  = size_half;
        tmp    = rand_bits(1);
        lane   = {tmp[0], 1'b0};
        mask   = 32'h0000_ffff << (8 * lane);
        placed = 32'(word[15:0]) << (8 * lane);
      end
      shadow[base[IDX_BITS+1:2]] = (shadow[base[IDX_BITS+1:2]] & ~mask) | (placed & mask);
      store(base + 32'(lane), wsize, word);
      load_and_compare("data_out", base, {1'b0, size_word}, shadow[base[IDX_BITS+1:2]]);
    end

    // LED register
    tmp = rand_bits(4);
    nib = tmp[3:0];
    store(`RAMIO_ADDR_LED, size_word, {28'h0, nib});
    assert (led === nib) else flag_mismatch("led", {28'h0, nib}, {28'h0, led});
    load_and_compare("led", `RAMIO_ADDR_LED, {1'b0, size_word}, {28'h0, nib});

    // UART send, upper data bits must not show in the register
    word    = rand_bits(32);
    tx_byte = word[7:0];
    store(`RAMIO_ADDR_UART_OUT, size_word, word);
    sent_at = $time;
    load_and_compare("uart_out", `RAMIO_ADDR_UART_OUT, {1'b0, size_word}, {24'h0, tx_byte});
    tx_drain(tx_byte, sent_at);
    rx_collect(tx_byte);
    load_and_compare("uart_in", `RAMIO_ADDR_UART_IN, {1'b0, size_word}, 32'hffff_ffff);
    assert (tx_line === 1'b1) else flag_mismatch("uart_tx", 32'h1, {31'h0, tx_line});

    $display("Test passed");
    $finish;
  end

endmodule

//--- list.f
+incdir+hdl
hdl/ramio_pkg.sv
hdl/mem_port_if.sv
hdl/word_ram.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/ramio.sv
hdl/soc_io_top.sv
bench/tb_soc_io.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the soc_io_top testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_soc_io -f list.f

# the simulation exits nonzero on a failed check, the log decides
./obj_dir/Vtb_soc_io > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
  echo "run.sh: simulation ok"
  exit 0
else
  echo "run.sh: simulation failed"
  exit 1
fi
